// ==== common/noc_config.svh ====
// Mesh size, flit data width, buffer depths and port count of the NoC
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

////////////////////
// Mesh geometry
////////////////////

// Mesh width and height in routers
`define NOC_X 2
`define NOC_Y 2

// Total node count
`define NOC_NODES (`NOC_X * `NOC_Y)

// Width of a node number in a header flit
`define NOC_NODE_BITS 2

////////////////////
// Link and buffers
////////////////////

// Payload bits per flit, last bit comes on top
`define NOC_DATA_WIDTH 32

// Flits held per input and per output port
`define NOC_BUF_IN_DEPTH  4
`define NOC_BUF_OUT_DEPTH 4

// Local plus four mesh directions
`define NOC_PORTS 5

`endif

// ==== common/noc_pkg.sv ====
// Flit struct, port index and direction types, node number type, coordinate helpers
`default_nettype none

package noc_pkg;

  `include "noc_config.svh"

  ////////////////////
  // Link payload
  ////////////////////

  // One flit on a link
  // Last marks the tail of a packet
  typedef struct packed {
    logic                       last;
    logic [`NOC_DATA_WIDTH-1:0] data;
  } flit_t;

  ////////////////////
  // Router ports
  ////////////////////

  // Port indices inside a router
  // North is towards higher y, east towards higher x
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    SOUTH = 3'd3,
    WEST  = 3'd4
  } port_e;

  // One-hot output selection, bit index follows port_e
  typedef logic [`NOC_PORTS-1:0] dir_t;

  ////////////////////
  // Node numbering
  ////////////////////

  // Node number as carried in the low bits of a header
  typedef logic [`NOC_NODE_BITS-1:0] node_t;

  // Column of a node, node = x + y * NOC_X
  function automatic int node_x(node_t n);
    return int'(n) % `NOC_X;
  endfunction

  // Row of a node
  function automatic int node_y(node_t n);
    return int'(n) / `NOC_X;
  endfunction

endpackage

`default_nettype wire

// ==== logic/noc_flit_fifo.sv ====
// Show-ahead synchronous flit FIFO with full and empty flags
`timescale 1ns/100ps
`default_nettype none

module noc_flit_fifo
  import noc_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr,
  input  flit_t wr_flit,
  input  logic  rd,
  output flit_t head,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Flit storage
  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////
  // Pointers and fill level
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Fill level moves only on a lone read or write
      if (wr && !rd) begin
        count <= count + 1'b1;
      end else if (rd && !wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  // Head is shown before the read strobe
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // Callers must respect the flags
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) !(wr && full));
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty));

endmodule

`default_nettype wire

// ==== router/noc_input_port.sv ====
// Router input port with flit buffer and XY route computation held per packet
`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_input_port
  import noc_pkg::*;
#(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,
  input  logic  pop,
  output flit_t head,
  output dir_t  req
);

  logic  buf_empty;
  logic  buf_full;
  node_t dest;
  int    dest_x;
  int    dest_y;
  dir_t  route_new;
  dir_t  route_q;
  logic  pkt_open;

  ////////////////////
  // Input buffer
  ////////////////////

  // Ready depends on fill level only
  assign in_ready = !buf_full;

  noc_flit_fifo #(
    .DEPTH (`NOC_BUF_IN_DEPTH)
  ) i_in_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (in_valid && in_ready),
    .wr_flit (in_flit),
    .rd      (pop),
    .head    (head),
    .empty   (buf_empty),
    .full    (buf_full)
  );

  ////////////////////
  // XY routing
  ////////////////////

  // Destination sits in the low data bits of a header
  assign dest   = head.data[`NOC_NODE_BITS-1:0];
  assign dest_x = node_x(dest);
  assign dest_y = node_y(dest);

  // Resolve X first and turn into Y only in the right column
  always_comb begin
    route_new = '0;
    if (dest_x > X_POS) begin
      route_new[EAST] = 1'b1;
    end else if (dest_x < X_POS) begin
      route_new[WEST] = 1'b1;
    end else if (dest_y > Y_POS) begin
      route_new[NORTH] = 1'b1;
    end else if (dest_y < Y_POS) begin
      route_new[SOUTH] = 1'b1;
    end else begin
      route_new[LOCAL] = 1'b1;
    end
  end

  // Packet is open from header pop until tail pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pkt_open <= 1'b0;
    end else if (pop) begin
      pkt_open <= !head.last;
    end
  end

  // Keep the header route for the body flits
  always_ff @(posedge clk) begin
    if (pop && !pkt_open) begin
      route_q <= route_new;
    end
  end

  // Body flits follow the stored route
  assign req = buf_empty ? '0 : (pkt_open ? route_q : route_new);

  // A waiting head keeps its request until it pops
  a_req_hold : assert property (@(posedge clk) disable iff (!rst_n)
    !buf_empty && !pop |=> $stable(req));

endmodule

`default_nettype wire

// ==== router/noc_output_arbiter.sv ====
// Round-robin output arbiter with wormhole lock, crossbar mux and output buffer
`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_output_arbiter
  import noc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`NOC_PORTS-1:0] req_bits,
  input  flit_t [`NOC_PORTS-1:0] heads,
  output logic [`NOC_PORTS-1:0] pop,
  output flit_t                 out_flit,
  output logic                  out_valid,
  input  logic                  out_ready
);

  localparam int IDX_W = $clog2(`NOC_PORTS);

  logic [`NOC_PORTS-1:0] rr_pick;
  logic [`NOC_PORTS-1:0] gnt;
  logic [`NOC_PORTS-1:0] grant_q;
  logic                  locked;
  logic [IDX_W-1:0]      last_idx;
  logic [IDX_W-1:0]      pick_idx;
  flit_t                 sel_flit;
  logic                  buf_empty;
  logic                  buf_full;

  ////////////////////
  // Round-robin pick
  ////////////////////

  // Search starts one past the previous winner
  always_comb begin
    int   idx;
    logic found;
    rr_pick  = '0;
    pick_idx = last_idx;
    found    = 1'b0;
    for (int i = 1; i <= `NOC_PORTS; i++) begin
      idx = (int'(last_idx) + i) % `NOC_PORTS;
      if (!found && req_bits[idx]) begin
        found        = 1'b1;
        rr_pick[idx] = 1'b1;
        pick_idx     = IDX_W'(idx);
      end
    end
  end

  // Locked grant wins until the tail has passed
  assign gnt = locked ? grant_q : rr_pick;

  // Pop only when the output buffer has room
  assign pop = gnt & req_bits & {`NOC_PORTS{!buf_full}};

  ////////////////////
  // Crossbar column
  ////////////////////

  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      if (gnt[i]) begin
        sel_flit = heads[i];
      end
    end
  end

  // Wormhole lock
  // Header locks, tail releases, single-flit packets never lock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked   <= 1'b0;
      grant_q  <= '0;
      last_idx <= '0;
    end else if (|pop) begin
      locked  <= !sel_flit.last;
      grant_q <= sel_flit.last ? '0 : gnt;
      if (!locked) begin
        last_idx <= pick_idx;
      end
    end
  end

  ////////////////////
  // Output buffer
  ////////////////////

  noc_flit_fifo #(
    .DEPTH (`NOC_BUF_OUT_DEPTH)
  ) i_out_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (|pop),
    .wr_flit (sel_flit),
    .rd      (out_valid && out_ready),
    .head    (out_flit),
    .empty   (buf_empty),
    .full    (buf_full)
  );

  assign out_valid = !buf_empty;

  // At most one input moves per cycle
  a_pop_onehot0 : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop));

  // A stalled flit stays put on the link
  a_out_hold : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

`default_nettype wire

// ==== router/noc_router.sv ====
// Five-port wormhole router built from input ports, crossbar arbiters and output buffers
`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_router
  import noc_pkg::*;
#(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  flit_t [`NOC_PORTS-1:0] in_flit,
  input  logic  [`NOC_PORTS-1:0] in_valid,
  output logic  [`NOC_PORTS-1:0] in_ready,
  output flit_t [`NOC_PORTS-1:0] out_flit,
  output logic  [`NOC_PORTS-1:0] out_valid,
  input  logic  [`NOC_PORTS-1:0] out_ready
);

  // Head flits seen by every arbiter
  flit_t [`NOC_PORTS-1:0] heads;
  // Requests indexed by input
  dir_t                   req     [`NOC_PORTS];
  // Requests indexed by output
  logic [`NOC_PORTS-1:0]  req_col [`NOC_PORTS];
  // Pop strobes indexed by output
  logic [`NOC_PORTS-1:0]  pop_out [`NOC_PORTS];
  // Pop strobes merged per input
  logic [`NOC_PORTS-1:0]  pop_in;

  ////////////////////
  // Input side
  ////////////////////

  for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_in
    noc_input_port #(
      .X_POS (X_POS),
      .Y_POS (Y_POS)
    ) i_input_port (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_flit  (in_flit[i]),
      .in_valid (in_valid[i]),
      .in_ready (in_ready[i]),
      .pop      (pop_in[i]),
      .head     (heads[i]),
      .req      (req[i])
    );

    // XY routing never sends a flit back where it came from
    if (i != int'(LOCAL)) begin : g_no_uturn
      a_no_uturn : assert property (@(posedge clk) disable iff (!rst_n) !req[i][i]);
    end
  end

  ////////////////////
  // Request and pop matrix
  ////////////////////

  // Turn input rows into output columns
  always_comb begin
    for (int o = 0; o < `NOC_PORTS; o++) begin
      for (int i = 0; i < `NOC_PORTS; i++) begin
        req_col[o][i] = req[i][o];
      end
    end
  end

  // An input is popped by whichever output granted it
  always_comb begin
    pop_in = '0;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      pop_in = pop_in | pop_out[o];
    end
  end

  ////////////////////
  // Output side
  ////////////////////

  for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_out
    noc_output_arbiter i_output_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_bits  (req_col[o]),
      .heads     (heads),
      .pop       (pop_out[o]),
      .out_flit  (out_flit[o]),
      .out_valid (out_valid[o]),
      .out_ready (out_ready[o])
    );
  end

endmodule

`default_nettype wire

// ==== logic/noc_mesh.sv ====
// Mesh top with a router per node, neighbour links, edge tie-offs and local ports
`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_mesh
  import noc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  flit_t [`NOC_NODES-1:0] in_flit,
  input  logic  [`NOC_NODES-1:0] in_valid,
  output logic  [`NOC_NODES-1:0] in_ready,
  output flit_t [`NOC_NODES-1:0] out_flit,
  output logic  [`NOC_NODES-1:0] out_valid,
  input  logic  [`NOC_NODES-1:0] out_ready
);

  // Per-router link bundles indexed by node then port
  wire flit_t [`NOC_PORTS-1:0] r_in_flit   [`NOC_NODES];
  wire logic  [`NOC_PORTS-1:0] r_in_valid  [`NOC_NODES];
  wire logic  [`NOC_PORTS-1:0] r_in_ready  [`NOC_NODES];
  wire flit_t [`NOC_PORTS-1:0] r_out_flit  [`NOC_NODES];
  wire logic  [`NOC_PORTS-1:0] r_out_valid [`NOC_NODES];
  wire logic  [`NOC_PORTS-1:0] r_out_ready [`NOC_NODES];

  for (genvar n = 0; n < `NOC_NODES; n++) begin : g_node
    localparam node_t ID    = node_t'(n);
    localparam int    X_POS = node_x(ID);
    localparam int    Y_POS = node_y(ID);

    noc_router #(
      .X_POS (X_POS),
      .Y_POS (Y_POS)
    ) i_router (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (r_in_flit[n]),
      .in_valid  (r_in_valid[n]),
      .in_ready  (r_in_ready[n]),
      .out_flit  (r_out_flit[n]),
      .out_valid (r_out_valid[n]),
      .out_ready (r_out_ready[n])
    );

    ////////////////////
    // Local port
    ////////////////////

    assign r_in_flit[n][LOCAL]   = in_flit[n];
    assign r_in_valid[n][LOCAL]  = in_valid[n];
    assign in_ready[n]           = r_in_ready[n][LOCAL];
    assign out_flit[n]           = r_out_flit[n][LOCAL];
    assign out_valid[n]          = r_out_valid[n][LOCAL];
    assign r_out_ready[n][LOCAL] = out_ready[n];

    ////////////////////
    // Mesh links
    ////////////////////

    // North neighbour sits one row up
    if (Y_POS < `NOC_Y - 1) begin : g_north
      assign r_in_flit[n][NORTH]   = r_out_flit[n + `NOC_X][SOUTH];
      assign r_in_valid[n][NORTH]  = r_out_valid[n + `NOC_X][SOUTH];
      assign r_out_ready[n][NORTH] = r_in_ready[n + `NOC_X][SOUTH];
    end else begin : g_north_edge
      assign r_in_flit[n][NORTH]   = '0;
      assign r_in_valid[n][NORTH]  = 1'b0;
      assign r_out_ready[n][NORTH] = 1'b0;
    end

    if (X_POS < `NOC_X - 1) begin : g_east
      assign r_in_flit[n][EAST]   = r_out_flit[n + 1][WEST];
      assign r_in_valid[n][EAST]  = r_out_valid[n + 1][WEST];
      assign r_out_ready[n][EAST] = r_in_ready[n + 1][WEST];
    end else begin : g_east_edge
      assign r_in_flit[n][EAST]   = '0;
      assign r_in_valid[n][EAST]  = 1'b0;
      assign r_out_ready[n][EAST] = 1'b0;
    end

    if (Y_POS > 0) begin : g_south
      assign r_in_flit[n][SOUTH]   = r_out_flit[n - `NOC_X][NORTH];
      assign r_in_valid[n][SOUTH]  = r_out_valid[n - `NOC_X][NORTH];
      assign r_out_ready[n][SOUTH] = r_in_ready[n - `NOC_X][NORTH];
    end else begin : g_south_edge
      assign r_in_flit[n][SOUTH]   = '0;
      assign r_in_valid[n][SOUTH]  = 1'b0;
      assign r_out_ready[n][SOUTH] = 1'b0;
    end

    // Boundary ports never receive and never accept
    if (X_POS > 0) begin : g_west
      assign r_in_flit[n][WEST]   = r_out_flit[n - 1][EAST];
      assign r_in_valid[n][WEST]  = r_out_valid[n - 1][EAST];
      assign r_out_ready[n][WEST] = r_in_ready[n - 1][EAST];
    end else begin : g_west_edge
      assign r_in_flit[n][WEST]   = '0;
      assign r_in_valid[n][WEST]  = 1'b0;
      assign r_out_ready[n][WEST] = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_noc_mesh.sv ====
// Testbench for the NoC mesh with clock, reset, LFSR, scoreboard, directed tests and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module tb_noc_mesh
  import noc_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int NODES       = `NOC_NODES;
  localparam int BP_PKTS     = 10;
  localparam int RAND_PKTS   = 16;
  localparam int DRAIN_LIMIT = 500;
  // Flits sent by all tests together and a generous cycle bound for each
  localparam int TOTAL_FLITS = NODES * NODES + 16 + BP_PKTS * 4 + NODES * RAND_PKTS * 4;
  localparam int FLIT_CYCLES = 40;

  logic               clk;
  logic               rst_n;
  flit_t [NODES-1:0]  in_flit;
  logic  [NODES-1:0]  in_valid;
  logic  [NODES-1:0]  in_ready;
  flit_t [NODES-1:0]  out_flit;
  logic  [NODES-1:0]  out_valid;
  logic  [NODES-1:0]  out_ready;

  // One queue of expected flits per source and destination pair
  flit_t       sb_q [NODES*NODES][$];
  int          seq_cnt [NODES];
  logic        pkt_open [NODES];
  int          open_src [NODES];
  logic [NODES-1:0] hold_ready;
  logic        random_ready;
  logic [15:0] lfsr;
  int          dst_tab [NODES][RAND_PKTS];
  int          len_tab [NODES][RAND_PKTS];
  int          done_cnt;
  int          checks;
  int          errors;

  noc_mesh i_noc_mesh (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #(CLK_PERIOD / 2) clk = !clk;

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (out_bit) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out_bit;
  endfunction

  function automatic int lfsr_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr_step());
    end
    return val;
  endfunction

  // Fields from the top are marker, length, index, sequence and source
  // Low bits hold the destination in a header and an offset node in body flits
  // so that body flits reach the right node only through the latched route
  function automatic flit_t make_flit(input int src, input int dst, input int seq,
                                      input int idx, input int len);
    flit_t f;
    f.last = (idx == len - 1);
    f.data = {12'h5A3, 4'(len), 4'(idx), 8'(seq), node_t'(src), node_t'(dst + idx)};
    return f;
  endfunction

  function automatic int sb_pending();
    int total;
    total = 0;
    for (int k = 0; k < NODES * NODES; k++) begin
      total += sb_q[k].size();
    end
    return total;
  endfunction

  // Queue the expected flits, then hand them over one per accepted cycle
  task automatic send_packet(input int src, input int dst, input int len);
    int seq;
    seq = seq_cnt[src];
    seq_cnt[src]++;
    for (int i = 0; i < len; i++) begin
      sb_q[src * NODES + dst].push_back(make_flit(src, dst, seq, i, len));
    end
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      in_flit[src]  = make_flit(src, dst, seq, i, len);
      in_valid[src] = 1'b1;
      // Ready is stable at the falling edge and a high ready moves the flit next
      while (!in_ready[src]) begin
        @(negedge clk);
      end
    end
    @(negedge clk);
    in_valid[src] = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while (sb_pending() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (sb_pending() != 0) begin
      errors++;
      $display("ERROR at %0t: %s left %0d flits undelivered", $time, what, sb_pending());
    end
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  // Picks out_ready and records every flit that leaves on the next rising edge
  always @(negedge clk) begin
    flit_t got;
    flit_t exp;
    int    s;
    if (rst_n) begin
      for (int d = 0; d < NODES; d++) begin
        if (random_ready) begin
          out_ready[d] = (lfsr_bits(2) != 0);
        end else begin
          out_ready[d] = !hold_ready[d];
        end
        if (out_valid[d] && out_ready[d]) begin
          got = out_flit[d];
          // Body flits must belong to the packet already open at this node
          s = pkt_open[d] ? open_src[d] : int'(got.data[2*`NOC_NODE_BITS-1:`NOC_NODE_BITS]);
          if (sb_q[s * NODES + d].size() == 0) begin
            errors++;
            $display("ERROR at %0t: node %0d delivered a flit nobody sent to it", $time, d);
          end else begin
            exp = sb_q[s * NODES + d].pop_front();
            checks++;
            if (got !== exp) begin
              errors++;
              $display("FAIL t=%0t out_flit[%0d] got=%h expected=%h", $time, d, got, exp);
            end
          end
          pkt_open[d] = !got.last;
          open_src[d] = s;
        end
      end
    end
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic check_reset();
    checks++;
    if (out_valid !== '0) begin
      errors++;
      $display("FAIL t=%0t out_valid got=%b expected=%b", $time, out_valid, {NODES{1'b0}});
    end
    checks++;
    if (in_ready !== '1) begin
      errors++;
      $display("FAIL t=%0t in_ready got=%b expected=%b", $time, in_ready, {NODES{1'b1}});
    end
  endtask

  // Single flit from every node to every node including loopback
  task automatic test_all_pairs();
    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        send_packet(s, d, 1);
        wait_drain("all-pairs test");
      end
    end
  endtask

  task automatic test_contention(input int src_a, input int src_b, input int dst);
    fork
      send_packet(src_a, dst, 4);
      send_packet(src_b, dst, 4);
    join
    wait_drain("contention test");
  endtask

  // Stall the destination until the sender sees in_ready drop
  task automatic test_backpressure(input int src, input int dst);
    @(posedge clk);
    hold_ready[dst] = 1'b1;
    fork
      for (int k = 0; k < BP_PKTS; k++) begin
        send_packet(src, dst, 4);
      end
      begin
        int waited;
        waited = 0;
        while (in_ready[src] && waited < DRAIN_LIMIT) begin
          @(negedge clk);
          waited++;
        end
        checks++;
        if (in_ready[src]) begin
          errors++;
          $display("ERROR at %0t: in_ready of node %0d never fell under a stall", $time, src);
        end
        @(posedge clk);
        hold_ready[dst] = 1'b0;
      end
    join
    wait_drain("back-pressure test");
  endtask

  task automatic test_random_traffic();
    for (int s = 0; s < NODES; s++) begin
      for (int k = 0; k < RAND_PKTS; k++) begin
        dst_tab[s][k] = lfsr_bits(`NOC_NODE_BITS);
        len_tab[s][k] = lfsr_bits(2) + 1;
      end
    end
    done_cnt = 0;
    @(posedge clk);
    random_ready = 1'b1;
    for (int n = 0; n < NODES; n++) begin
      fork
        automatic int s = n;
        begin
          for (int k = 0; k < RAND_PKTS; k++) begin
            send_packet(s, dst_tab[s][k], len_tab[s][k]);
          end
          done_cnt++;
        end
      join_none
    end
    wait (done_cnt == NODES);
    wait_drain("random traffic test");
    @(posedge clk);
    random_ready = 1'b0;
  endtask

  ////////////////////
  // Sequence and watchdog
  ////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_flit      = '0;
    in_valid     = '0;
    out_ready    = '1;
    hold_ready   = '0;
    random_ready = 1'b0;
    lfsr         = 16'd93;
    checks       = 0;
    errors       = 0;
    for (int n = 0; n < NODES; n++) begin
      seq_cnt[n]  = 0;
      pkt_open[n] = 1'b0;
      open_src[n] = 0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset();
    test_all_pairs();
    test_contention(0, 3, 1);
    test_contention(1, 2, 0);
    test_backpressure(0, 3);
    test_random_traffic();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TOTAL_FLITS * FLIT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, traffic did not complete in time");
    $display("checks: %0d  errors: %0d", checks, errors + 1);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/noc_pkg.sv
logic/noc_flit_fifo.sv
router/noc_input_port.sv
router/noc_output_arbiter.sv
router/noc_router.sv
logic/noc_mesh.sv
testbench/tb_noc_mesh.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the NoC mesh testbench with Verilator, run it and check the log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_noc_mesh -o sim_noc_mesh \
  && ./obj_dir/sim_noc_mesh | tee sim.log \
  && grep -q "^TESTS PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
